/* Bender.yml */
package:
  name: frame_gen

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pcs_block_pkg.sv
      - common/gen_ctrl_pkg.sv
      - design/frame_req_rx.sv
      - frame_gen/cgmii_seq_fsm.sv
      - frame_gen/payload_lfsr.sv
      - frame_gen/block_encoder.sv
      - design/tx_out_stage.sv
      - design/frame_gen_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/frame_gen_tb.sv

/* common/gen_cfg.svh */
`ifndef GEN_CFG_SVH
`define GEN_CFG_SVH

// block format widths
`define NB_DATA_RAW		64
`define NB_CTRL_RAW		8

// descriptor field widths
`define NB_NDATA		8		// data blocks per frame
`define NB_NIDLE		5		// idle blocks before a frame
`define NB_TERM			3		// trailing bytes in the terminate block

// xorshift64 must never start from zero
`define PAYLOAD_SEED	64'h2545_f491_4f6c_dd1d

`endif

/* common/gen_ctrl_pkg.sv */
`default_nettype none
`include "gen_cfg.svh"

package gen_ctrl_pkg;

	// one-hot, one bit per block type
	typedef enum logic [5:0]
	{
		ST_INIT		= 6'b000001,	// sequence ordered set after reset
		ST_IDLE		= 6'b000010,
		ST_START	= 6'b000100,
		ST_DATA		= 6'b001000,
		ST_TERM		= 6'b010000,
		ST_ERR		= 6'b100000
	} seq_state_t;

	// descriptor fields
	typedef logic [`NB_NDATA-1:0]	ndata_t;
	typedef logic [`NB_NIDLE-1:0]	nidle_t;
	typedef logic [`NB_TERM-1:0]	nterm_t;

endpackage

`default_nettype wire

/* common/pcs_block_pkg.sv */
`default_nettype none
`include "gen_cfg.svh"

package pcs_block_pkg;

	typedef logic [`NB_DATA_RAW-1:0]	data_word_t;	// lane 0 in the top byte
	typedef logic [`NB_CTRL_RAW-1:0]	ctrl_word_t;	// msb flags lane 0
	typedef logic [7:0]					char_t;

	// control characters
	localparam char_t		IDLE_CHAR	= 8'h07;
	localparam char_t		START_CHAR	= 8'hFB;
	localparam char_t		TERM_CHAR	= 8'hFD;
	localparam char_t		ERROR_CHAR	= 8'hFE;

	// fixed blocks
	localparam data_word_t	Q_ORD_BLOCK	= 64'h9C68_7973_0000_0000;	// sequence ordered set
	localparam data_word_t	IDLE_BLOCK	= {8{IDLE_CHAR}};
	localparam data_word_t	ERROR_BLOCK	= {8{ERROR_CHAR}};

	// control masks
	localparam ctrl_word_t	ORD_CTRL	= 8'h80;
	localparam ctrl_word_t	IDLE_CTRL	= 8'hFF;	// error blocks too
	localparam ctrl_word_t	START_CTRL	= 8'h80;
	localparam ctrl_word_t	DATA_CTRL	= 8'h00;

	// n trailing data bytes leave the first n lanes clear
	function automatic ctrl_word_t term_ctrl(input logic [`NB_TERM-1:0] n);
		return IDLE_CTRL >> n;
	endfunction

endpackage

`default_nettype wire

/* design/frame_gen_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gen_cfg.svh"

module frame_gen_top
	import pcs_block_pkg::*;
	import gen_ctrl_pkg::*;
(
	input wire logic		i_clock,
	input wire logic		i_rst_n,
	input wire logic		i_req,
	input wire ndata_t		i_ndata,
	input wire nidle_t		i_nidle,
	input wire nterm_t		i_nterm,
	input wire logic		i_poison,
	output logic			o_ack,
	input wire logic		i_ready,
	output data_word_t		o_tx_data,
	output ctrl_word_t		o_tx_ctrl,
	output logic			o_valid
);

	logic		desc_valid;
	logic		desc_take;
	ndata_t		desc_ndata;
	nidle_t		desc_nidle;
	nterm_t		desc_nterm;
	logic		desc_poison;
	seq_state_t	state;
	nterm_t		term_bytes;
	logic		advance;
	logic		stall;
	data_word_t	payload;
	data_word_t	enc_data;
	ctrl_word_t	enc_ctrl;

	frame_req_rx u_frame_req_rx
	(
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_req			(i_req),
		.i_ndata		(i_ndata),
		.i_nidle		(i_nidle),
		.i_nterm		(i_nterm),
		.i_poison		(i_poison),
		.o_ack			(o_ack),
		.i_desc_take	(desc_take),
		.o_desc_valid	(desc_valid),
		.o_ndata		(desc_ndata),
		.o_nidle		(desc_nidle),
		.o_nterm		(desc_nterm),
		.o_poison		(desc_poison)
	);

	cgmii_seq_fsm u_cgmii_seq_fsm
	(
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_stall		(stall),
		.i_desc_valid	(desc_valid),
		.i_ndata		(desc_ndata),
		.i_nidle		(desc_nidle),
		.i_nterm		(desc_nterm),
		.i_poison		(desc_poison),
		.o_desc_take	(desc_take),
		.o_state		(state),
		.o_term_bytes	(term_bytes),
		.o_advance		(advance)
	);

	payload_lfsr u_payload_lfsr
	(
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_advance		(advance),
		.o_payload		(payload)
	);

	block_encoder u_block_encoder
	(
		.i_state		(state),
		.i_payload		(payload),
		.i_term_bytes	(term_bytes),
		.o_tx_data		(enc_data),
		.o_tx_ctrl		(enc_ctrl)
	);

	tx_out_stage u_tx_out_stage
	(
		.i_clock		(i_clock),
		.i_rst_n		(i_rst_n),
		.i_tx_data		(enc_data),
		.i_tx_ctrl		(enc_ctrl),
		.i_ready		(i_ready),
		.o_tx_data		(o_tx_data),
		.o_tx_ctrl		(o_tx_ctrl),
		.o_valid		(o_valid),
		.o_stall		(stall)
	);

endmodule

`default_nettype wire

/* design/frame_req_rx.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gen_cfg.svh"

module frame_req_rx
	import gen_ctrl_pkg::*;
(
	input wire logic	i_clock,
	input wire logic	i_rst_n,
	// four-phase side
	input wire logic	i_req,
	input wire ndata_t	i_ndata,
	input wire nidle_t	i_nidle,
	input wire nterm_t	i_nterm,
	input wire logic	i_poison,
	output logic		o_ack,
	// sequencer side
	input wire logic	i_desc_take,
	output logic		o_desc_valid,
	output ndata_t		o_ndata,
	output nidle_t		o_nidle,
	output nterm_t		o_nterm,
	output logic		o_poison
);

	logic	ack_q;
	logic	slot_full;
	logic	accept;

	// new request only when the previous handshake is fully closed
	assign accept = i_req && !ack_q && !slot_full;

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			ack_q		<= 1'b0;
			slot_full	<= 1'b0;
		end
		else
		begin
			if (accept)
				ack_q <= 1'b1;
			else if (!i_req)
				ack_q <= 1'b0;		// sender released req
			if (accept)
				slot_full <= 1'b1;
			else if (i_desc_take)
				slot_full <= 1'b0;
		end
	end

	// fields are held stable by the sender while req is up
	always_ff @(posedge i_clock)
	begin
		if (accept)
		begin
			o_ndata		<= i_ndata;
			o_nidle		<= i_nidle;
			o_nterm		<= i_nterm;
			o_poison	<= i_poison;
		end
	end

	assign o_ack		= ack_q;
	assign o_desc_valid	= slot_full;

endmodule

`default_nettype wire

/* design/tx_out_stage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gen_cfg.svh"

module tx_out_stage
	import pcs_block_pkg::*;
(
	input wire logic		i_clock,
	input wire logic		i_rst_n,
	input wire data_word_t	i_tx_data,
	input wire ctrl_word_t	i_tx_ctrl,
	input wire logic		i_ready,
	output data_word_t		o_tx_data,
	output ctrl_word_t		o_tx_ctrl,
	output logic			o_valid,
	output logic			o_stall
);

	logic	valid_q;

	// hold the word until the sink takes it
	assign o_stall = valid_q && !i_ready;

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
			valid_q <= 1'b0;
		else if (!o_stall)
			valid_q <= 1'b1;		// a block every cycle once running
	end

	always_ff @(posedge i_clock)
	begin
		if (!o_stall)
		begin
			o_tx_data <= i_tx_data;
			o_tx_ctrl <= i_tx_ctrl;
		end
	end

	assign o_valid = valid_q;

endmodule

`default_nettype wire

/* frame_gen/block_encoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gen_cfg.svh"

module block_encoder
	import pcs_block_pkg::*;
	import gen_ctrl_pkg::*;
(
	input wire seq_state_t	i_state,
	input wire data_word_t	i_payload,
	input wire nterm_t		i_term_bytes,
	output data_word_t		o_tx_data,
	output ctrl_word_t		o_tx_ctrl
);

	localparam int	N_LANES = `NB_CTRL_RAW;

	data_word_t	term_blk [N_LANES];
	ctrl_word_t	term_msk [N_LANES];
	data_word_t	start_blk;

	// terminate variant n keeps payload lanes 0..n-1, then T, then idles
	for (genvar n = 0; n < N_LANES; n++)
	begin : g_term
		for (genvar k = 0; k < N_LANES; k++)
		begin : g_lane
			if (k < n)
			begin : g_pay
				assign term_blk[n][`NB_DATA_RAW-1-8*k -: 8] = i_payload[`NB_DATA_RAW-1-8*k -: 8];
			end
			else if (k == n)
			begin : g_t
				assign term_blk[n][`NB_DATA_RAW-1-8*k -: 8] = TERM_CHAR;
			end
			else
			begin : g_idle
				assign term_blk[n][`NB_DATA_RAW-1-8*k -: 8] = IDLE_CHAR;
			end
		end
		assign term_msk[n] = term_ctrl(nterm_t'(n));
	end

	assign start_blk = {START_CHAR, i_payload[`NB_DATA_RAW-9:0]};	// lane 0 replaced

	always_comb
	begin
		o_tx_data = IDLE_BLOCK;
		o_tx_ctrl = IDLE_CTRL;
		case (i_state)
			ST_INIT:
			begin
				o_tx_data = Q_ORD_BLOCK;
				o_tx_ctrl = ORD_CTRL;
			end
			ST_START:
			begin
				o_tx_data = start_blk;
				o_tx_ctrl = START_CTRL;
			end
			ST_DATA:
			begin
				o_tx_data = i_payload;
				o_tx_ctrl = DATA_CTRL;
			end
			ST_TERM:
			begin
				o_tx_data = term_blk[i_term_bytes];
				o_tx_ctrl = term_msk[i_term_bytes];
			end
			ST_ERR:
			begin
				o_tx_data = ERROR_BLOCK;
				o_tx_ctrl = IDLE_CTRL;
			end
			default: ;		// idle
		endcase
	end

endmodule

`default_nettype wire

/* frame_gen/cgmii_seq_fsm.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gen_cfg.svh"

module cgmii_seq_fsm
	import gen_ctrl_pkg::*;
(
	input wire logic	i_clock,
	input wire logic	i_rst_n,
	input wire logic	i_stall,
	// descriptor slot
	input wire logic	i_desc_valid,
	input wire ndata_t	i_ndata,
	input wire nidle_t	i_nidle,
	input wire nterm_t	i_nterm,
	input wire logic	i_poison,
	output logic		o_desc_take,
	// to encoder and payload generator
	output seq_state_t	o_state,
	output nterm_t		o_term_bytes,
	output logic		o_advance
);

	seq_state_t	state;
	seq_state_t	end_state;
	nidle_t		idle_cnt;		// idles still owed before start
	ndata_t		data_cnt;		// data blocks still owed
	nterm_t		nterm_q;
	logic		poison_q;
	logic		frame_end;
	logic		can_take;

	assign frame_end	= (state == ST_TERM) || (state == ST_ERR);
	assign end_state	= poison_q ? ST_ERR : ST_TERM;

	// a descriptor is loaded on the end block itself so back to back frames keep exact gaps
	assign can_take		= frame_end || ((state == ST_IDLE) && (idle_cnt == '0));
	assign o_desc_take	= !i_stall && i_desc_valid && can_take;

	// every block type that consumes a payload word
	assign o_advance	= !i_stall && ((state == ST_START) || (state == ST_DATA) || frame_end);

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
		begin
			state		<= ST_INIT;
			idle_cnt	<= '0;
			data_cnt	<= '0;
			nterm_q		<= '0;
			poison_q	<= 1'b0;
		end
		else if (!i_stall)
		begin
			if (o_desc_take)
			begin
				idle_cnt	<= i_nidle;
				data_cnt	<= i_ndata;
				nterm_q		<= i_nterm;
				poison_q	<= i_poison;
				state		<= (i_nidle == '0) ? ST_START : ST_IDLE;
			end
			else
			begin
				case (state)
					ST_INIT:	state <= ST_IDLE;		// ordered set goes out once
					ST_IDLE:
					begin
						if (idle_cnt != '0)
						begin
							idle_cnt <= idle_cnt - 1'b1;
							if (idle_cnt == nidle_t'(1))
								state <= ST_START;
						end
					end
					ST_START:	state <= (data_cnt == '0) ? end_state : ST_DATA;
					ST_DATA:
					begin
						data_cnt <= data_cnt - 1'b1;
						if (data_cnt == ndata_t'(1))
							state <= end_state;
					end
					ST_TERM,
					ST_ERR:		state <= ST_IDLE;
					default:	state <= ST_INIT;
				endcase
			end
		end
	end

	assign o_state		= state;
	assign o_term_bytes	= nterm_q;

endmodule

`default_nettype wire

/* frame_gen/payload_lfsr.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gen_cfg.svh"

module payload_lfsr
	import pcs_block_pkg::*;
(
	input wire logic	i_clock,
	input wire logic	i_rst_n,
	input wire logic	i_advance,
	output data_word_t	o_payload
);

	data_word_t	lfsr_q;
	data_word_t	step1;
	data_word_t	step2;
	data_word_t	step3;

	// xorshift64, shifts 13 / 7 / 17
	assign step1 = lfsr_q ^ (lfsr_q << 13);
	assign step2 = step1 ^ (step1 >> 7);
	assign step3 = step2 ^ (step2 << 17);

	always_ff @(posedge i_clock)
	begin
		if (!i_rst_n)
			lfsr_q <= `PAYLOAD_SEED;
		else if (i_advance)
			lfsr_q <= step3;
	end

	assign o_payload = lfsr_q;

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/pcs_block_pkg.sv
common/gen_ctrl_pkg.sv
design/frame_req_rx.sv
frame_gen/cgmii_seq_fsm.sv
frame_gen/payload_lfsr.sv
frame_gen/block_encoder.sv
design/tx_out_stage.sv
design/frame_gen_top.sv
verif/frame_gen_tb.sv

/* verif/frame_gen_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "gen_cfg.svh"

module frame_gen_tb
	import pcs_block_pkg::*;
	import gen_ctrl_pkg::*;
();

	localparam int	DRV			= 10;		// drive delay after the rising edge
	localparam int	ACK_WAIT	= 2000;

	// {poison, nterm, nidle, ndata}
	typedef logic [`NB_NDATA+`NB_NIDLE+`NB_TERM:0]	desc_t;

	logic			clock;
	logic			rst_n;
	logic			req;
	ndata_t			ndata;
	nidle_t			nidle;
	nterm_t			nterm;
	logic			poison;
	logic			ack;
	logic			ready;
	data_word_t		tx_data;
	ctrl_word_t		tx_ctrl;
	logic			valid;

	int				cyc = 0;
	int				cycle_limit = 100;
	data_word_t		model_lfsr;			// reference payload state
	logic [31:0]	lcg_state;
	logic			rand_ready;
	desc_t			desc_tab [16];
	int				desc_cnt;
	int				ack_at [16];
	int				end_at [16];
	data_word_t		beat_data [$];		// accepted beats in order
	ctrl_word_t		beat_ctrl [$];
	int				beat_cyc [$];

	frame_gen_top dut_i
	(
		.i_clock	(clock),
		.i_rst_n	(rst_n),
		.i_req		(req),
		.i_ndata	(ndata),
		.i_nidle	(nidle),
		.i_nterm	(nterm),
		.i_poison	(poison),
		.o_ack		(ack),
		.i_ready	(ready),
		.o_tx_data	(tx_data),
		.o_tx_ctrl	(tx_ctrl),
		.o_valid	(valid)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// a beat seen here is taken on the next rising edge
	always @(negedge clock)
	begin
		if (valid && ready)
		begin
			beat_data.push_back(tx_data);
			beat_ctrl.push_back(tx_ctrl);
			beat_cyc.push_back(cyc + 1);
		end
	end

	always @(posedge clock)
	begin
		cyc <= cyc + 1;
		if (cyc > cycle_limit)
			abort_run($sformatf("timeout, the run passed its limit of %0d cycles", cycle_limit));
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
		input string what);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED at time %0t: %s (got %h, expected %h)",
				$time, what, got, expected));
	endtask

	function automatic data_word_t xorshift_next(input data_word_t s);
		data_word_t	t;
		t = s ^ (s << 13);
		t = t ^ (t >> 7);
		t = t ^ (t << 17);
		return t;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// payload lanes below n, then T, then idles
	function automatic data_word_t term_word(input data_word_t pay, input nterm_t n);
		data_word_t	w;
		int			k;
		for (k = 0; k < 8; k++)
		begin
			if (k < n)
				w[63-8*k -: 8] = pay[63-8*k -: 8];
			else if (k == n)
				w[63-8*k -: 8] = TERM_CHAR;
			else
				w[63-8*k -: 8] = IDLE_CHAR;
		end
		return w;
	endfunction

	task automatic next_beat(output data_word_t d, output ctrl_word_t c, output int at);
		while (beat_data.size() == 0)
			@(posedge clock);
		d	= beat_data.pop_front();
		c	= beat_ctrl.pop_front();
		at	= beat_cyc.pop_front();
	endtask

	task automatic send_desc(input desc_t desc, output int ack_cyc);
		int	waited;
		{poison, nterm, nidle, ndata} = desc;
		req = 1'b1;
		waited = 0;
		@(posedge clock);
		#DRV;
		while (!ack)
		begin
			waited++;
			if (waited > ACK_WAIT)
				abort_run("frame request was never acknowledged");
			@(posedge clock);
			#DRV;
		end
		ack_cyc = cyc;
		req = 1'b0;
		@(posedge clock);
		#DRV;
		check_value(ack, 1'b0, "ack falls after req is released");
	endtask

	task automatic expect_frame(input int idx, input logic exact_gap, output int end_cyc);
		ndata_t		nd;
		nidle_t		ni;
		nterm_t		nt;
		logic		pz;
		data_word_t	d;
		ctrl_word_t	c;
		int			at;
		int			gap;
		int			fresh;
		int			k;
		int			idle_at [$];
		{pz, nt, ni, nd} = desc_tab[idx];
		gap = 0;
		next_beat(d, c, at);
		while (d == {8{IDLE_CHAR}} && c == 8'hFF)
		begin
			gap++;
			idle_at.push_back(at);
			next_beat(d, c, at);
		end
		if (exact_gap)
			check_value(gap, ni, "idle count between frames");
		else
		begin
			// only idles after the ack can belong to this frame
			fresh = 0;
			for (k = 0; k < idle_at.size(); k++)
				if (idle_at[k] > ack_at[idx])
					fresh++;
			check_value(fresh >= ni, 1'b1, "minimum idle count before frame");
		end
		check_value(d, {START_CHAR, model_lfsr[55:0]}, "start block");
		check_value(c, 8'h80, "start mask");
		model_lfsr = xorshift_next(model_lfsr);
		for (k = 0; k < nd; k++)
		begin
			next_beat(d, c, at);
			check_value(d, model_lfsr, "data block");
			check_value(c, 8'h00, "data mask");
			model_lfsr = xorshift_next(model_lfsr);
		end
		next_beat(d, c, at);
		if (pz)
			check_value(d, {8{ERROR_CHAR}}, "error block");
		else
			check_value(d, term_word(model_lfsr, nt), "terminate block");
		check_value(c, pz ? 8'hFF : (8'hFF >> nt), "end block mask");
		model_lfsr = xorshift_next(model_lfsr);		// error blocks consume a word too
		end_cyc = at;
	endtask

	task automatic add_frame(input ndata_t nd, input nidle_t ni, input nterm_t nt, input logic pz);
		desc_tab[desc_cnt] = {pz, nt, ni, nd};
		desc_cnt++;
	endtask

	// sender and checker run side by side over the queued frames
	task automatic run_frames(input int slow);
		ndata_t	nd;
		nidle_t	ni;
		nterm_t	nt;
		logic	pz;
		int		budget;
		int		i;
		int		j;
		budget = 50;
		for (i = 0; i < desc_cnt; i++)
		begin
			{pz, nt, ni, nd} = desc_tab[i];
			budget += (nd + ni + 10) * slow;	// blocks plus handshake
		end
		cycle_limit = cyc + budget;
		@(posedge clock);
		#DRV;
		fork
			for (i = 0; i < desc_cnt; i++)
				send_desc(desc_tab[i], ack_at[i]);
			for (j = 0; j < desc_cnt; j++)
				expect_frame(j, j > 0, end_at[j]);
		join
		desc_cnt = 0;
	endtask

	task automatic check_startup();
		data_word_t	d;
		ctrl_word_t	c;
		int			at;
		int			k;
		check_value(valid, 1'b0, "valid during reset");
		check_value(ack, 1'b0, "ack during reset");
		rst_n = 1'b1;
		@(posedge clock);
		#DRV;
		check_value(valid, 1'b1, "valid one cycle after reset");
		next_beat(d, c, at);
		check_value(d, Q_ORD_BLOCK, "ordered set block");
		check_value(c, 8'h80, "ordered set mask");
		for (k = 0; k < 4; k++)
		begin
			next_beat(d, c, at);
			check_value(d, {8{IDLE_CHAR}}, "idle block without descriptor");
			check_value(c, 8'hFF, "idle mask");
		end
	endtask

	task automatic single_frame_test();
		add_frame(6, 4, 5, 1'b0);
		run_frames(1);
	endtask

	task automatic back_to_back_test();
		int	n;
		for (n = 0; n < 8; n++)
			add_frame(3 + n, 3, n, 1'b0);
		run_frames(1);
	endtask

	task automatic poison_test();
		add_frame(4, 2, 3, 1'b1);
		add_frame(5, 2, 6, 1'b0);
		run_frames(1);
	endtask

	task automatic stall_test();
		int	k;
		for (k = 0; k < 4; k++)
			add_frame(4 + 2 * k, 1 + k, 2 * k + 1, k == 2);
		rand_ready = 1'b1;
		@(posedge clock);
		#DRV;
		fork
			begin
				run_frames(8);
				rand_ready = 1'b0;
			end
			while (rand_ready)
			begin
				lcg_state = lcg_next(lcg_state);
				ready = lcg_state[30];	// upper bits, the low ones cycle fast
				@(posedge clock);
				#DRV;
			end
		join
		ready = 1'b1;
	endtask

	task automatic slot_full_test();
		add_frame(20, 2, 1, 1'b0);
		add_frame(2, 1, 4, 1'b0);		// sits in the slot during the long frame
		add_frame(3, 2, 7, 1'b0);
		run_frames(1);
		check_value(ack_at[2], end_at[0], "ack of request made while slot full");
	endtask

	initial
	begin
		rst_n		= 1'b0;
		req			= 1'b0;
		ndata		= '0;
		nidle		= '0;
		nterm		= '0;
		poison		= 1'b0;
		ready		= 1'b1;
		rand_ready	= 1'b0;
		desc_cnt	= 0;
		model_lfsr	= `PAYLOAD_SEED;
		lcg_state	= 32'h386f_f975;
		repeat (3)
			@(posedge clock);
		#DRV;
		check_startup();
		single_frame_test();
		back_to_back_test();
		poison_test();
		stall_test();
		slot_full_test();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
